// File: common/isaPkg.sv
// ISA package for the 32-bit five-stage core
// Opcodes, ALU function codes and instruction field positions
`default_nettype none

package isaPkg;

    localparam int wordWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int opWidth      = 5;     // Opcode and ALU function code share this width

    // Primary opcode in instr[31:27]
    typedef enum logic [opWidth-1:0] {
        opAlu  = 5'b00000,  // R type, function in aluOp field
        opJ    = 5'b00001,  // PC = N
        opBne  = 5'b00010,  // if (rd != rs) PC = PC+1+N
        opJal  = 5'b00011,  // r31 = PC+1, PC = N
        opJr   = 5'b00100,  // PC = rd
        opAddi = 5'b00101,
        opBlt  = 5'b00110,  // if (rd < rs) PC = PC+1+N
        opSw   = 5'b00111,  // MEM[rs+N] = rd
        opLw   = 5'b01000   // rd = MEM[rs+N]
    } opcodeT;

    // R-type function code in instr[6:2]
    typedef enum logic [opWidth-1:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101
    } aluOpT;

    // Top bit of each field
    localparam int opcodeMsb = 31;
    localparam int rdMsb     = 26;   // Also top of the 27-bit jump target
    localparam int rsMsb     = 21;
    localparam int rtMsb     = 16;
    localparam int shamtMsb  = 11;
    localparam int aluOpMsb  = 6;
    localparam int immMsb    = 16;   // 17-bit signed immediate

    localparam logic [regAddrWidth-1:0] returnReg = 5'd31;  // jal link register
    localparam logic [regAddrWidth-1:0] zeroReg   = '0;
    localparam logic [wordWidth-1:0]    nopWord   = '0;     // add r0,r0,r0

endpackage

`default_nettype wire

// File: common/pipePkg.sv
// Pipeline types shared by the stages
// Decoded instruction, stage latches, bypass select and redirect
`default_nettype none

package pipePkg;

    typedef struct packed {
        isaPkg::opcodeT                          opcode;
        isaPkg::aluOpT                           aluOp;
        logic [isaPkg::regAddrWidth-1:0]         shamt;
        logic [isaPkg::regAddrWidth-1:0]         srcA;     // zeroReg when unused
        logic [isaPkg::regAddrWidth-1:0]         srcB;     // zeroReg when unused
        logic [isaPkg::regAddrWidth-1:0]         dest;
        logic                                    writes;   // Never set for r0
        logic                                    usesImm;
        logic                                    isLoad;
        logic                                    isStore;
        logic                                    isBranchNe;
        logic                                    isBranchLt;
        logic                                    isJump;   // j and jal
        logic                                    isJal;
        logic                                    isJr;
    } decodedT;

    typedef struct packed {
        logic [isaPkg::wordWidth-1:0] pc;
        logic [isaPkg::wordWidth-1:0] instr;
        decodedT                      dec;
        logic [isaPkg::wordWidth-1:0] a;
        logic [isaPkg::wordWidth-1:0] b;
    } dxLatchT;

    typedef struct packed {
        decodedT                      dec;
        logic [isaPkg::wordWidth-1:0] result;    // ALU result or memory address
        logic [isaPkg::wordWidth-1:0] storeVal;
    } xmLatchT;

    typedef struct packed {
        logic [isaPkg::regAddrWidth-1:0] dest;
        logic                            writes;
        logic [isaPkg::wordWidth-1:0]    result;
    } mwLatchT;

    typedef enum logic [1:0] {
        file,
        fromMem,
        fromWb
    } bypassSelT;

    typedef struct packed {
        logic                         valid;
        logic [isaPkg::wordWidth-1:0] target;
    } redirectT;

endpackage

`default_nettype wire

// File: src/instrDecoder.sv
// Instruction decoder
// Splits one instruction word into opcode, ALU op, register numbers and flags
`default_nettype none

module instrDecoder (
    input  logic [isaPkg::wordWidth-1:0] instr,
    output pipePkg::decodedT             dec
);

    logic [isaPkg::regAddrWidth-1:0] rd;
    logic [isaPkg::regAddrWidth-1:0] rs;
    logic [isaPkg::regAddrWidth-1:0] rt;
    logic [isaPkg::opWidth-1:0]      funct;

    assign rd    = instr[isaPkg::rdMsb -: isaPkg::regAddrWidth];
    assign rs    = instr[isaPkg::rsMsb -: isaPkg::regAddrWidth];
    assign rt    = instr[isaPkg::rtMsb -: isaPkg::regAddrWidth];
    assign funct = instr[isaPkg::aluOpMsb -: isaPkg::opWidth];

    always_comb begin
        dec        = '0;
        dec.opcode = isaPkg::opcodeT'(instr[isaPkg::opcodeMsb -: isaPkg::opWidth]);
        dec.shamt  = instr[isaPkg::shamtMsb -: isaPkg::regAddrWidth];
        dec.aluOp  = isaPkg::aluAdd;           // Address and link arithmetic
        case (dec.opcode)
            isaPkg::opAlu: begin
                if (funct <= isaPkg::aluSra) begin
                    dec.aluOp = isaPkg::aluOpT'(funct);
                end
                dec.srcA   = rs;
                dec.srcB   = rt;
                dec.dest   = rd;
                dec.writes = 1'b1;
            end
            isaPkg::opAddi, isaPkg::opLw: begin
                dec.srcA    = rs;
                dec.dest    = rd;
                dec.writes  = 1'b1;
                dec.usesImm = 1'b1;
                dec.isLoad  = (dec.opcode == isaPkg::opLw);
            end
            isaPkg::opSw: begin
                dec.srcA    = rs;          // Base
                dec.srcB    = rd;          // Store data
                dec.usesImm = 1'b1;
                dec.isStore = 1'b1;
            end
            isaPkg::opBne, isaPkg::opBlt: begin
                dec.srcA       = rd;       // Compared as rd against rs
                dec.srcB       = rs;
                dec.isBranchNe = (dec.opcode == isaPkg::opBne);
                dec.isBranchLt = (dec.opcode == isaPkg::opBlt);
            end
            isaPkg::opJ: dec.isJump = 1'b1;
            isaPkg::opJal: begin
                dec.isJump = 1'b1;
                dec.isJal  = 1'b1;
                dec.dest   = isaPkg::returnReg;
                dec.writes = 1'b1;
            end
            isaPkg::opJr: begin
                dec.srcA = rd;
                dec.isJr = 1'b1;
            end
            default: ;                     // Unsupported opcode runs as a nop
        endcase
        if (dec.dest == isaPkg::zeroReg) dec.writes = 1'b0;  // r0 stays zero
    end

endmodule

`default_nettype wire

// File: src/hazardControl.sv
// Pipeline control
// Load-use stall, redirect flush, and operand and store-data bypass selects
`default_nettype none

module hazardControl (
    input  logic [isaPkg::regAddrWidth-1:0] decSrcA,
    input  logic [isaPkg::regAddrWidth-1:0] decSrcB,
    input  logic                            decUsesB,
    input  pipePkg::decodedT                exDec,
    input  pipePkg::decodedT                memDec,
    input  logic [isaPkg::regAddrWidth-1:0] wbDest,
    input  logic                            wbWrite,
    input  pipePkg::redirectT               redirect,
    output logic                            stall,
    output logic                            flush,
    output pipePkg::bypassSelT              bypassA,
    output pipePkg::bypassSelT              bypassB,
    output logic                            storeBypass
);

    // Youngest producer wins and r0 never forwards
    function automatic pipePkg::bypassSelT pickSource(
        input logic [isaPkg::regAddrWidth-1:0] src
    );
        if (memDec.writes && memDec.dest != isaPkg::zeroReg && memDec.dest == src) begin
            return pipePkg::fromMem;
        end
        if (wbWrite && wbDest != isaPkg::zeroReg && wbDest == src) begin
            return pipePkg::fromWb;
        end
        return pipePkg::file;
    endfunction

    logic exLoadDest;     // Load in execute with a real destination

    assign exLoadDest = exDec.isLoad && exDec.dest != isaPkg::zeroReg;
    assign stall = exLoadDest &&
                   (exDec.dest == decSrcA || (decUsesB && exDec.dest == decSrcB));
    assign flush = redirect.valid;         // Kill fetch and decode

    always_comb begin
        bypassA = pickSource(exDec.srcA);
        bypassB = pickSource(exDec.srcB);
    end

    // W result into store data in M
    assign storeBypass = memDec.isStore && wbWrite &&
                         memDec.srcB != isaPkg::zeroReg && wbDest == memDec.srcB;

endmodule

`default_nettype wire

// File: src/fetchStage.sv
// Fetch stage
// PC register and fetch/decode latch with redirect, stall and flush
`default_nettype none

module fetchStage (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         flush,
    input  pipePkg::redirectT            redirect,
    input  logic [isaPkg::wordWidth-1:0] q_imem,
    output logic [isaPkg::wordWidth-1:0] address_imem,
    output logic [isaPkg::wordWidth-1:0] decPc,
    output logic [isaPkg::wordWidth-1:0] decInstr
);

    logic [isaPkg::wordWidth-1:0] pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect.valid) begin
            pc <= redirect.target;         // Taken branch or jump from execute
        end else if (!stall) begin
            pc <= pc + isaPkg::wordWidth'(1);
        end
    end

    assign address_imem = pc;

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            decPc    <= '0;
            decInstr <= isaPkg::nopWord;   // Squashed slot
        end else if (!stall) begin
            decPc    <= pc;
            decInstr <= q_imem;
        end
    end

endmodule

`default_nettype wire

// File: execute/alu.sv
// ALU for the execute stage
// add, sub, and, or, sll, sra plus signed compare flags for branches
`default_nettype none

module alu (
    input  logic [isaPkg::wordWidth-1:0]    opA,
    input  logic [isaPkg::wordWidth-1:0]    opB,
    input  isaPkg::aluOpT                   aluOp,
    input  logic [isaPkg::regAddrWidth-1:0] shamt,
    output logic [isaPkg::wordWidth-1:0]    result,
    output logic                            notEqual,
    output logic                            lessThan
);

    always_comb begin
        case (aluOp)
            isaPkg::aluAdd: result = opA + opB;
            isaPkg::aluSub: result = opA - opB;
            isaPkg::aluAnd: result = opA & opB;
            isaPkg::aluOr:  result = opA | opB;
            isaPkg::aluSll: result = opA << shamt;
            isaPkg::aluSra: result = $signed(opA) >>> shamt;  // Sign fill
            default:        result = opA + opB;
        endcase
    end

    assign notEqual = (opA != opB);
    assign lessThan = ($signed(opA) < $signed(opB));

endmodule

`default_nettype wire

// File: execute/executeStage.sv
// Execute stage
// Decode/execute latch, operand bypass, ALU, branch and jump resolution,
// and the execute/memory latch
`default_nettype none

module executeStage (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         flush,
    input  logic [isaPkg::wordWidth-1:0] decPc,
    input  logic [isaPkg::wordWidth-1:0] decInstr,   // Immediate and target source
    input  pipePkg::decodedT             decDec,
    input  logic [isaPkg::wordWidth-1:0] readA,
    input  logic [isaPkg::wordWidth-1:0] readB,
    input  pipePkg::bypassSelT           bypassA,
    input  pipePkg::bypassSelT           bypassB,
    input  logic [isaPkg::wordWidth-1:0] memResult,
    input  logic [isaPkg::wordWidth-1:0] wbResult,
    output pipePkg::decodedT             exDec,
    output pipePkg::redirectT            redirect,
    output pipePkg::xmLatchT             xm
);

    localparam int W = isaPkg::wordWidth;

    pipePkg::dxLatchT dx;
    logic [W-1:0]     fwdA;
    logic [W-1:0]     fwdB;
    logic [W-1:0]     imm;
    logic [W-1:0]     opA;
    logic [W-1:0]     opB;
    logic [W-1:0]     aluResult;
    logic             notEqual;
    logic             lessThan;
    logic             taken;

    function automatic logic [W-1:0] forward(
        input pipePkg::bypassSelT sel,
        input logic [W-1:0]       fromFile
    );
        case (sel)
            pipePkg::fromMem: return memResult;
            pipePkg::fromWb:  return wbResult;
            default:          return fromFile;
        endcase
    endfunction

    always_ff @(posedge clock) begin
        if (rst || stall || flush) begin
            dx <= '0;                      // Bubble decodes as a nop
        end else begin
            dx.pc    <= decPc;
            dx.instr <= decInstr;
            dx.dec   <= decDec;
            dx.a     <= readA;
            dx.b     <= readB;
        end
    end

    assign exDec = dx.dec;

    always_comb begin
        fwdA = forward(bypassA, dx.a);
        fwdB = forward(bypassB, dx.b);
    end

    assign imm   = {{(W-isaPkg::immMsb-1){dx.instr[isaPkg::immMsb]}},
                    dx.instr[isaPkg::immMsb:0]};

    // jal computes PC+1 for the link register
    assign opA = dx.dec.isJal ? dx.pc : fwdA;
    assign opB = dx.dec.isJal ? W'(1) : (dx.dec.usesImm ? imm : fwdB);

    alu uAlu (
        .opA      (opA),
        .opB      (opB),
        .aluOp    (dx.dec.aluOp),
        .shamt    (dx.dec.shamt),
        .result   (aluResult),
        .notEqual (notEqual),
        .lessThan (lessThan)
    );

    assign taken = (dx.dec.isBranchNe && notEqual) || (dx.dec.isBranchLt && lessThan);

    always_comb begin
        redirect.valid = taken || dx.dec.isJump || dx.dec.isJr;
        if (dx.dec.isJr) begin
            redirect.target = fwdA;
        end else if (dx.dec.isJump) begin
            redirect.target = {{(W-isaPkg::rdMsb-1){1'b0}}, dx.instr[isaPkg::rdMsb:0]};
        end else begin
            redirect.target = dx.pc + W'(1) + imm;   // PC-relative
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            xm <= '0;
        end else begin
            xm.dec      <= dx.dec;
            xm.result   <= aluResult;
            xm.storeVal <= fwdB;           // May still be patched from W in M
        end
    end

endmodule

`default_nettype wire

// File: src/memWriteback.sv
// Memory and writeback stages
// Data memory ports with store bypass, memory/writeback latch, register write port
`default_nettype none

module memWriteback (
    input  logic                            clock,
    input  logic                            rst,
    input  pipePkg::xmLatchT                xm,
    input  logic [isaPkg::wordWidth-1:0]    q_dmem,
    input  logic                            storeBypass,
    output logic [isaPkg::wordWidth-1:0]    address_dmem,
    output logic [isaPkg::wordWidth-1:0]    data,
    output logic                            wren,
    output pipePkg::decodedT                memDec,
    output logic [isaPkg::wordWidth-1:0]    memResult,
    output logic                            ctrl_writeEnable,
    output logic [isaPkg::regAddrWidth-1:0] ctrl_writeReg,
    output logic [isaPkg::wordWidth-1:0]    data_writeReg
);

    pipePkg::mwLatchT mw;

    assign address_dmem = xm.result;                              // rs + N
    assign data         = storeBypass ? mw.result : xm.storeVal;
    assign wren         = xm.dec.isStore;
    assign memDec       = xm.dec;
    assign memResult    = xm.result;

    always_ff @(posedge clock) begin
        if (rst) begin
            mw <= '0;
        end else begin
            mw.dest   <= xm.dec.dest;
            mw.writes <= xm.dec.writes;
            mw.result <= xm.dec.isLoad ? q_dmem : xm.result;
        end
    end

    // Register file write port
    assign ctrl_writeEnable = mw.writes;
    assign ctrl_writeReg    = mw.dest;
    assign data_writeReg    = mw.result;

endmodule

`default_nettype wire

// File: src/processor.sv
// Five-stage pipelined processor top level
// Connects the stages to the external instruction memory, data memory and register file
`default_nettype none

module processor (
    input  logic                            clock,
    input  logic                            rst,
    output logic [isaPkg::wordWidth-1:0]    address_imem,
    input  logic [isaPkg::wordWidth-1:0]    q_imem,
    output logic [isaPkg::wordWidth-1:0]    address_dmem,
    output logic [isaPkg::wordWidth-1:0]    data,
    output logic                            wren,
    input  logic [isaPkg::wordWidth-1:0]    q_dmem,
    output logic                            ctrl_writeEnable,
    output logic [isaPkg::regAddrWidth-1:0] ctrl_writeReg,
    output logic [isaPkg::regAddrWidth-1:0] ctrl_readRegA,
    output logic [isaPkg::regAddrWidth-1:0] ctrl_readRegB,
    output logic [isaPkg::wordWidth-1:0]    data_writeReg,
    input  logic [isaPkg::wordWidth-1:0]    data_readRegA,
    input  logic [isaPkg::wordWidth-1:0]    data_readRegB
);

    logic [isaPkg::wordWidth-1:0] decPc;
    logic [isaPkg::wordWidth-1:0] decInstr;
    logic [isaPkg::wordWidth-1:0] memResult;
    logic                         stall;
    logic                         flush;
    logic                         storeBypass;
    pipePkg::decodedT             decDec;
    pipePkg::decodedT             exDec;
    pipePkg::decodedT             memDec;
    pipePkg::redirectT            redirect;
    pipePkg::xmLatchT             xm;
    pipePkg::bypassSelT           bypassA;
    pipePkg::bypassSelT           bypassB;

    fetchStage uFetch (
        .clock, .rst, .stall, .flush, .redirect, .q_imem,
        .address_imem, .decPc, .decInstr
    );

    // Decode is combinational, register numbers go straight to the file
    instrDecoder uDecode (.instr(decInstr), .dec(decDec));
    assign ctrl_readRegA = decDec.srcA;
    assign ctrl_readRegB = decDec.srcB;

    hazardControl uHazard (
        .decSrcA  (decDec.srcA),
        .decSrcB  (decDec.srcB),
        .decUsesB (!decDec.usesImm),      // sw data is patched in M, never stalls
        .exDec, .memDec,
        .wbDest   (ctrl_writeReg),
        .wbWrite  (ctrl_writeEnable),
        .redirect, .stall, .flush, .bypassA, .bypassB, .storeBypass
    );

    executeStage uExecute (
        .clock, .rst, .stall, .flush, .decPc, .decInstr, .decDec,
        .readA    (data_readRegA),
        .readB    (data_readRegB),
        .bypassA, .bypassB, .memResult,
        .wbResult (data_writeReg),
        .exDec, .redirect, .xm
    );

    memWriteback uMemWb (
        .clock, .rst, .xm, .q_dmem, .storeBypass,
        .address_dmem, .data, .wren, .memDec, .memResult,
        .ctrl_writeEnable, .ctrl_writeReg, .data_writeReg
    );

endmodule

`default_nettype wire

// File: test/processorSva.sv
// Port assertions for the processor
// Reset state, no poison writes, r0 never written
`default_nettype none

module processorSva (
    input logic        clock,
    input logic        rst,
    input logic        wren,
    input logic        writeEnable,
    input logic [4:0]  writeReg,
    input logic [31:0] writeData,
    input logic [31:0] imemAddr
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] poisonValue = 32'h0000_dead;  // Shadow instructions load this

    // Every latch is a nop right after reset
    resetState: assert property (@(posedge clock)
        rst |=> (!wren && !writeEnable && imemAddr == 32'd0))
        else $error("Outputs not idle after reset");

    // Squashed instructions never reach writeback
    noPoison: assert property (@(posedge clock) disable iff (rst)
        writeEnable |-> writeData != poisonValue)
        else $error("Poison value written to r%0d", writeReg);

    noZeroWrite: assert property (@(posedge clock) disable iff (rst)
        writeEnable |-> writeReg != 5'd0)
        else $error("Write strobe for r0");

endmodule

bind processor processorSva uSva (
    .clock       (clock),
    .rst         (rst),
    .wren        (wren),
    .writeEnable (ctrl_writeEnable),
    .writeReg    (ctrl_writeReg),
    .writeData   (data_writeReg),
    .imemAddr    (address_imem)
);

`default_nettype wire

// File: test/processorTb.sv
// Testbench for the five-stage processor
// Memory and register-file models, one test program, expected-write checks
`default_nettype none

module processorTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int resetCycles = 5;
    localparam logic [31:0] lcgSeed = 32'hf233_368f;
    localparam logic [16:0] poisonImm = 17'h0dead;   // Never a legal result

    logic        clock;
    logic        rst;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic [31:0] q_dmem;
    logic [31:0] data_writeReg;
    logic [31:0] data_readRegA;
    logic [31:0] data_readRegB;
    logic        wren;
    logic        ctrl_writeEnable;
    logic [4:0]  ctrl_writeReg;
    logic [4:0]  ctrl_readRegA;
    logic [4:0]  ctrl_readRegB;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:255];
    logic [31:0] memInit [0:255];   // Copy of the preload for expected values
    logic [31:0] regs [0:31];
    int progLen;

    logic [4:0]  expReg [$];   // Register writes in program order
    logic [31:0] expVal [$];
    string       expName [$];
    logic [31:0] stAddr [$];   // Stores in program order
    logic [31:0] stData [$];

    processor i_dut (.*);

    always #50 clock = ~clock;

    // Combinational reads with write-through on a same-cycle write
    assign q_imem = imem[address_imem[5:0]];
    assign q_dmem = dmem[address_dmem[7:0]];
    assign data_readRegA = (ctrl_writeEnable && ctrl_writeReg == ctrl_readRegA &&
                            ctrl_readRegA != 5'd0) ? data_writeReg : regs[ctrl_readRegA];
    assign data_readRegB = (ctrl_writeEnable && ctrl_writeReg == ctrl_readRegB &&
                            ctrl_readRegB != 5'd0) ? data_writeReg : regs[ctrl_readRegB];

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rtype(input isaPkg::aluOpT fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] shamt);
        return {isaPkg::opAlu, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic logic [31:0] itype(input isaPkg::opcodeT op, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic logic [31:0] jtype(input isaPkg::opcodeT op, input logic [26:0] t);
        return {op, t};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic expectWrite(input string name, input logic [4:0] r, input logic [31:0] v);
        expName.push_back(name);
        expReg.push_back(r);
        expVal.push_back(v);
    endtask

    task automatic failValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic failPlain(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic buildProgram();
        // ALU chain where every operand comes from the previous results
        emit(itype(isaPkg::opAddi, 5'd1, 5'd0, 17'd5));
        expectWrite("aluChain", 1, 5);
        emit(itype(isaPkg::opAddi, 5'd2, 5'd1, 17'd3));
        expectWrite("aluChain", 2, 8);
        emit(rtype(isaPkg::aluAdd, 5'd3, 5'd2, 5'd1, 0));
        expectWrite("aluChain", 3, 13);
        emit(rtype(isaPkg::aluSub, 5'd4, 5'd3, 5'd1, 0));
        expectWrite("aluChain", 4, 8);
        emit(rtype(isaPkg::aluAnd, 5'd5, 5'd4, 5'd3, 0));
        expectWrite("aluChain", 5, 8);
        emit(rtype(isaPkg::aluOr, 5'd6, 5'd5, 5'd1, 0));
        expectWrite("aluChain", 6, 13);
        emit(rtype(isaPkg::aluSll, 5'd7, 5'd6, 5'd0, 4));
        expectWrite("aluChain", 7, 208);
        emit(itype(isaPkg::opAddi, 5'd8, 5'd0, 17'h1ffc0)); // -64
        expectWrite("aluChain", 8, 32'hffff_ffc0);
        emit(rtype(isaPkg::aluSra, 5'd9, 5'd8, 5'd0, 3));
        expectWrite("aluChain", 9, 32'hffff_fff8);
        emit(itype(isaPkg::opAddi, 5'd10, 5'd9, 17'd100));
        expectWrite("aluChain", 10, 92);
        emit(itype(isaPkg::opAddi, 5'd0, 5'd10, 17'd7));  // Targets r0 so nothing is written
        emit(rtype(isaPkg::aluAdd, 5'd11, 5'd0, 5'd10, 0));
        expectWrite("r0Read", 11, 92);

        // Load use and store data patched from M and from W, then read back
        emit(itype(isaPkg::opAddi, 5'd12, 5'd0, 17'd16));
        expectWrite("loadStore", 12, 16);
        emit(itype(isaPkg::opLw, 5'd13, 5'd12, 17'd0));
        expectWrite("loadStore", 13, memInit[16]);
        emit(rtype(isaPkg::aluAdd, 5'd14, 5'd13, 5'd1, 0));
        expectWrite("loadUse", 14, memInit[16] + 5);
        emit(itype(isaPkg::opLw, 5'd15, 5'd12, 17'd1));
        expectWrite("loadStore", 15, memInit[17]);
        emit(itype(isaPkg::opSw, 5'd15, 5'd12, 17'd2));
        stAddr.push_back(18);
        stData.push_back(memInit[17]);
        emit(itype(isaPkg::opAddi, 5'd16, 5'd14, 17'd1));
        expectWrite("loadStore", 16, memInit[16] + 6);
        emit(itype(isaPkg::opSw, 5'd16, 5'd12, 17'd3));
        stAddr.push_back(19);
        stData.push_back(memInit[16] + 6);
        emit(itype(isaPkg::opLw, 5'd17, 5'd12, 17'd3));
        expectWrite("loadBack", 17, memInit[16] + 6);

        // Branches taken and not taken with poison in every shadow
        emit(itype(isaPkg::opAddi, 5'd18, 5'd0, 17'd1));
        expectWrite("branches", 18, 1);
        emit(itype(isaPkg::opAddi, 5'd19, 5'd0, 17'd2));
        expectWrite("branches", 19, 2);
        emit(itype(isaPkg::opBne, 5'd18, 5'd19, 17'd2));  // Taken to 25
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opBne, 5'd18, 5'd18, 17'd2));  // Not taken
        emit(itype(isaPkg::opAddi, 5'd21, 5'd0, 17'd7));
        expectWrite("branches", 21, 7);
        emit(itype(isaPkg::opBlt, 5'd18, 5'd19, 17'd2));  // 1 < 2 so taken to 30
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opBlt, 5'd19, 5'd18, 17'd1));  // Not taken
        emit(itype(isaPkg::opAddi, 5'd22, 5'd0, 17'd9));
        expectWrite("branches", 22, 9);

        // j, jal to a subroutine, jr back
        emit(jtype(isaPkg::opJ, 27'd35));                 // 32
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(jtype(isaPkg::opJal, 27'd40));               // 35
        expectWrite("jumps", 31, 36);
        expectWrite("jumps", 24, 22);                     // Subroutine body first
        emit(itype(isaPkg::opAddi, 5'd23, 5'd0, 17'd11)); // 36 runs after the return
        expectWrite("jumps", 23, 11);
        emit(jtype(isaPkg::opJ, 27'd45));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opAddi, 5'd24, 5'd0, 17'd22)); // 40
        emit(itype(isaPkg::opJr, 5'd31, 5'd0, 17'd0));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(itype(isaPkg::opAddi, 5'd20, 5'd0, poisonImm));
        emit(jtype(isaPkg::opJ, 27'd45));                 // Halt loop
    endtask

    // Register and store checks at the rising edge where the models also update
    always @(posedge clock) begin
        if (!rst && ctrl_writeEnable && ctrl_writeReg != 5'd0) begin
            if (expReg.size() == 0) begin
                failPlain("Register write seen after all expected writes");
            end
            assert (ctrl_writeReg == expReg[0])
                else failValue({expName[0], " reg"}, 32'(expReg[0]), 32'(ctrl_writeReg));
            assert (data_writeReg == expVal[0])
                else failValue(expName[0], expVal[0], data_writeReg);
            void'(expReg.pop_front());
            void'(expVal.pop_front());
            void'(expName.pop_front());
        end
        if (!rst && wren) begin
            if (stAddr.size() == 0) begin
                failPlain("Store seen after all expected stores");
            end
            assert (address_dmem == stAddr[0])
                else failValue("storeAddr", stAddr[0], address_dmem);
            assert (data == stData[0])
                else failValue("storeData", stData[0], data);
            void'(stAddr.pop_front());
            void'(stData.pop_front());
            dmem[address_dmem[7:0]] <= data;
        end
        if (ctrl_writeEnable && ctrl_writeReg != 5'd0) begin
            regs[ctrl_writeReg] <= data_writeReg;
        end
    end

    initial begin
        logic [31:0] state;
        clock = 1'b0;
        rst = 1'b1;
        progLen = 0;
        state = lcgSeed;
        for (int i = 0; i < 256; i++) begin
            state = lcgNext(state);
            dmem[i] <= state;
            memInit[i] = state;
        end
        for (int i = 0; i < 32; i++) regs[i] <= '0;
        for (int i = 0; i < 64; i++) imem[i] = isaPkg::nopWord;
        buildProgram();
        repeat (resetCycles) @(negedge clock);
        rst = 1'b0;
        while (expReg.size() != 0 || stAddr.size() != 0) @(negedge clock);
        repeat (8) @(negedge clock);                      // Catch stray writes
        $display("All checks passed");
        $finish;
    end

    // Watchdog scaled to the program length
    initial begin
        #1;
        #((progLen * 10 + resetCycles) * 100);
        $display("Timeout with %0d register writes outstanding", expReg.size());
        $display("Checks failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: flist.f
common/isaPkg.sv
common/pipePkg.sv
src/instrDecoder.sv
src/hazardControl.sv
src/fetchStage.sv
execute/alu.sv
execute/executeStage.sv
src/memWriteback.sv
src/processor.sv
test/processorSva.sv
test/processorTb.sv

// File: Makefile
# Verilator simulation of the pipelined processor

VERILATOR ?= verilator
TOP       ?= processorTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
